/* build.f */
+incdir+logic
logic/rv_pkg.sv
logic/regfile.sv
logic/id_stage.sv
logic/alu.sv
logic/exe_core.sv
verification/exe_core_asserts.sv
verification/exe_core_tb.sv

/* logic/alu.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
  input  rv_pkg::xlen_t   op_a,
  input  rv_pkg::xlen_t   rs2_val,
  input  rv_pkg::xlen_t   imm,
  input  logic            use_imm,
  input  logic            word_op,
  input  rv_pkg::alu_op_t alu_op,
  output rv_pkg::xlen_t   result
);

  rv_pkg::xlen_t  op_b;
  rv_pkg::shamt_t shamt;
  rv_pkg::xlen_t  a_word_zext;
  rv_pkg::xlen_t  a_word_sext;
  rv_pkg::xlen_t  srl_src;
  rv_pkg::xlen_t  sra_src;
  rv_pkg::xlen_t  raw;

  // operand b from immediate or rs2
  assign op_b = use_imm ? imm : rs2_val;

  // word ops shift by 5 bits only
  assign shamt = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

  // right shifts on word ops start from the low half
  assign a_word_zext = {32'h0000_0000, op_a[31:0]};
  assign a_word_sext = {{32{op_a[31]}}, op_a[31:0]};
  assign srl_src     = word_op ? a_word_zext : op_a;
  assign sra_src     = word_op ? a_word_sext : op_a;

  always_comb begin
    case (alu_op)
      `ALU_ADD:  raw = op_a + op_b;
      `ALU_SUB:  raw = op_a - op_b;
      `ALU_SLL:  raw = op_a << shamt;
      // compares yield 0 or 1
      `ALU_SLT:  raw = {63'd0, $signed(op_a) < $signed(op_b)};
      `ALU_SLTU: raw = {63'd0, op_a < op_b};
      `ALU_XOR:  raw = op_a ^ op_b;
      `ALU_SRL:  raw = srl_src >> shamt;
      `ALU_OR:   raw = op_a | op_b;
      `ALU_AND:  raw = op_a & op_b;
      `ALU_SRA:  raw = rv_pkg::xlen_t'($signed(sra_src) >>> shamt);
      // lui immediate already shifted by the decoder
      `ALU_LUI:  raw = op_b;
      default:   raw = `ZERO_WORD;
    endcase
  end

  // W results are the low 32 bits sign-extended
  assign result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* logic/exe_core.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module exe_core (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::instr_t instr,
  input  logic           instr_valid,
  output logic           illegal_instr,
  output logic           writebacked,
  output rv_pkg::xlen_t  regs_o [`REG_COUNT]
);

  // decoder to register file
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  logic              rs1_ren;
  logic              rs2_ren;
  logic              rd_wen;

  // decoder to alu
  rv_pkg::xlen_t     imm;
  logic              use_imm;
  logic              word_op;
  rv_pkg::alu_op_t   alu_op;

  // operands and writeback data
  rv_pkg::xlen_t     rs1_data;
  rv_pkg::xlen_t     rs2_data;
  rv_pkg::xlen_t     result;

  id_stage u_id_stage (
    .instr         (instr),
    .instr_valid   (instr_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .rs1_ren       (rs1_ren),
    .rs2_ren       (rs2_ren),
    .rd_wen        (rd_wen),
    .imm           (imm),
    .use_imm       (use_imm),
    .word_op       (word_op),
    .alu_op        (alu_op),
    .illegal_instr (illegal_instr)
  );

  // read this cycle, write back at the next edge
  regfile u_regfile (
    .clk         (clk),
    .rst         (rst),
    .rs1         (rs1),
    .rs1_ren     (rs1_ren),
    .rs2         (rs2),
    .rs2_ren     (rs2_ren),
    .rd          (rd),
    .rd_wen      (rd_wen),
    .rd_data     (result),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .writebacked (writebacked),
    .regs_o      (regs_o)
  );

  alu u_alu (
    .op_a    (rs1_data),
    .rs2_val (rs2_data),
    .imm     (imm),
    .use_imm (use_imm),
    .word_op (word_op),
    .alu_op  (alu_op),
    .result  (result)
  );

endmodule

/* logic/id_stage.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module id_stage (
  input  rv_pkg::instr_t    instr,
  input  logic              instr_valid,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output logic              rs1_ren,
  output logic              rs2_ren,
  output logic              rd_wen,
  output rv_pkg::xlen_t     imm,
  output logic              use_imm,
  output logic              word_op,
  output rv_pkg::alu_op_t   alu_op,
  output logic              illegal_instr
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::funct7_t funct7;
  logic [5:0]      funct6;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_u;
  rv_pkg::alu_op_t f3_op;
  logic            legal;
  logic            rs1_use;
  logic            rs2_use;

  // fixed field positions
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];
  // shift immediates give up bit 25 to shamt[5]
  assign funct6 = instr[31:26];

  // sign-extended immediates
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'h000};

  // funct3 to alu op
  // bit 30 picks arithmetic right shift in both forms
  always_comb begin
    case (funct3)
      `RV_F3_ADD_SUB: f3_op = `ALU_ADD;
      `RV_F3_SLL:     f3_op = `ALU_SLL;
      `RV_F3_SLT:     f3_op = `ALU_SLT;
      `RV_F3_SLTU:    f3_op = `ALU_SLTU;
      `RV_F3_XOR:     f3_op = `ALU_XOR;
      `RV_F3_SRL_SRA: f3_op = instr[30] ? `ALU_SRA : `ALU_SRL;
      `RV_F3_OR:      f3_op = `ALU_OR;
      default:        f3_op = `ALU_AND;
    endcase
  end

  always_comb begin
    legal   = 1'b0;
    rs1_use = 1'b0;
    rs2_use = 1'b0;
    use_imm = 1'b0;
    word_op = 1'b0;
    imm     = imm_i;
    alu_op  = `ALU_ADD;
    case (opcode)
      `RV_OP_LUI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = `ALU_LUI;
      end
      `RV_OP_IMM: begin
        rs1_use = 1'b1;
        use_imm = 1'b1;
        alu_op  = f3_op;
        // only shifts constrain the upper bits
        case (funct3)
          `RV_F3_SLL:     legal = (funct6 == `RV_F6_SRL);
          `RV_F3_SRL_SRA: legal = (funct6 == `RV_F6_SRL) || (funct6 == `RV_F6_SRA);
          default:        legal = 1'b1;
        endcase
      end
      `RV_OP_REG: begin
        rs1_use = 1'b1;
        rs2_use = 1'b1;
        alu_op  = f3_op;
        // alt funct7 only valid for sub and sra
        legal   = (funct7 == `RV_F7_BASE) ||
                  ((funct7 == `RV_F7_ALT) &&
                   ((funct3 == `RV_F3_ADD_SUB) || (funct3 == `RV_F3_SRL_SRA)));
        if ((funct3 == `RV_F3_ADD_SUB) && (funct7 == `RV_F7_ALT)) begin
          alu_op = `ALU_SUB;
        end
      end
      `RV_OP_IMM32: begin
        // addiw only
        rs1_use = 1'b1;
        use_imm = 1'b1;
        word_op = 1'b1;
        legal   = (funct3 == `RV_F3_ADD_SUB);
      end
      `RV_OP_REG32: begin
        // addw and subw only
        rs1_use = 1'b1;
        rs2_use = 1'b1;
        word_op = 1'b1;
        legal   = (funct3 == `RV_F3_ADD_SUB) &&
                  ((funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT));
        alu_op  = (funct7 == `RV_F7_ALT) ? `ALU_SUB : `ALU_ADD;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // reads and writeback only for a valid, legal instruction
  assign rs1_ren       = instr_valid && legal && rs1_use;
  assign rs2_ren       = instr_valid && legal && rs2_use;
  assign rd_wen        = instr_valid && legal;
  assign illegal_instr = instr_valid && !legal;

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module regfile (
  input  logic              clk,
  input  logic              rst,
  // read port 1
  input  rv_pkg::reg_addr_t rs1,
  input  logic              rs1_ren,
  // read port 2
  input  rv_pkg::reg_addr_t rs2,
  input  logic              rs2_ren,
  // write port
  input  rv_pkg::reg_addr_t rd,
  input  logic              rd_wen,
  input  rv_pkg::xlen_t     rd_data,
  output rv_pkg::xlen_t     rs1_data,
  output rv_pkg::xlen_t     rs2_data,
  // high when the previous cycle wrote back
  output logic              writebacked,
  // difftest view of the architectural state
  output rv_pkg::xlen_t     regs_o [`REG_COUNT]
);

  rv_pkg::xlen_t regs [`REG_COUNT];

  // write on the edge, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= `ZERO_WORD;
      end
    end else if (rd_wen && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // read port 1, zero when idle or held in reset
  always_comb begin
    if (rst) begin
      rs1_data = `ZERO_WORD;
    end else if (rs1_ren) begin
      rs1_data = regs[rs1];
    end else begin
      rs1_data = `ZERO_WORD;
    end
  end

  // read port 2, same gating
  always_comb begin
    if (rst) begin
      rs2_data = `ZERO_WORD;
    end else if (rs2_ren) begin
      rs2_data = regs[rs2];
    end else begin
      rs2_data = `ZERO_WORD;
    end
  end

  // tracks last cycle's write
  // high out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      writebacked <= 1'b1;
    end else begin
      writebacked <= rd_wen;
    end
  end

  // difftest sees the pending write before it lands
  for (genvar i = 0; i < `REG_COUNT; i++) begin : g_difftest
    assign regs_o[i] = (rd_wen && (rd == rv_pkg::reg_addr_t'(i)) && (rd != '0)) ?
                       rd_data : regs[i];
  end

endmodule

/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// major opcodes handled by the execute core
`define RV_OP_LUI      7'b0110111
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`define RV_OP_IMM32    7'b0011011
`define RV_OP_REG32    7'b0111011

// funct3 encodings shared by register and immediate forms
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL_SRA  3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

// funct7 for register forms
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000

// upper six bits of a 64-bit shift immediate
`define RV_F6_SRL      6'b000000
`define RV_F6_SRA      6'b010000

// alu operation codes
`define ALU_ADD        4'd0
`define ALU_SUB        4'd1
`define ALU_SLL        4'd2
`define ALU_SLT        4'd3
`define ALU_SLTU       4'd4
`define ALU_XOR        4'd5
`define ALU_SRL        4'd6
`define ALU_OR         4'd7
`define ALU_AND        4'd8
`define ALU_SRA        4'd9
// pass operand b straight through
`define ALU_LUI        4'd10

`define REG_COUNT      32
`define ZERO_WORD      64'h0000_0000_0000_0000

`endif

/* logic/rv_pkg.sv */
package rv_pkg;

  // one architectural data word
  typedef logic [63:0] xlen_t;

  // register index, x0 .. x31
  typedef logic [4:0] reg_addr_t;

  // raw instruction as strobed in
  typedef logic [31:0] instr_t;

  // alu operation select
  typedef logic [3:0] alu_op_t;

  // major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  // minor opcode field, instr[14:12]
  typedef logic [2:0] funct3_t;

  // upper function field, instr[31:25]
  typedef logic [6:0] funct7_t;

  // shift amount
  // full 6 bits for rv64, bit 5 forced low on word ops
  typedef logic [5:0] shamt_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# compile and run the exe_core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module exe_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vexe_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verification/exe_core_asserts.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module exe_core_asserts (
  input logic          clk,
  input logic          rst,
  input logic          rd_wen,
  input logic          writebacked,
  input logic          rs1_ren,
  input rv_pkg::xlen_t rs1_data,
  input logic          rs2_ren,
  input rv_pkg::xlen_t rs2_data,
  input rv_pkg::xlen_t regs_o [`REG_COUNT]
);

  // x0 stays zero in the difftest view, bypass included
  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs_o[0] == '0)
    else $error("regs_o x0 is nonzero");

  // first cycle out of reset still shows the reset value
  a_wb_follows: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (writebacked == $past(rd_wen)))
    else $error("writebacked does not match the previous rd_wen");

  // gated read ports
  a_rs1_gated: assert property (@(posedge clk) disable iff (rst) !rs1_ren |-> (rs1_data == '0))
    else $error("rs1_data nonzero while rs1_ren is low");
  a_rs2_gated: assert property (@(posedge clk) disable iff (rst) !rs2_ren |-> (rs2_data == '0))
    else $error("rs2_data nonzero while rs2_ren is low");

endmodule

bind regfile exe_core_asserts u_exe_core_asserts (
  .clk         (clk),
  .rst         (rst),
  .rd_wen      (rd_wen),
  .writebacked (writebacked),
  .rs1_ren     (rs1_ren),
  .rs1_data    (rs1_data),
  .rs2_ren     (rs2_ren),
  .rs2_data    (rs2_data),
  .regs_o      (regs_o)
);

/* verification/exe_core_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module exe_core_tb;

  localparam int RESET_CYCLES = 10;

  // instruction kinds the table can encode
  typedef enum logic [4:0] {
    K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND,
    K_ADDI, K_SLTI, K_SLTIU, K_XORI, K_ORI, K_ANDI, K_SLLI, K_SRLI, K_SRAI,
    K_LUI, K_ADDW, K_SUBW, K_ADDIW, K_ILL
  } op_kind_t;

  // imm holds imm[11:0], a shamt, or the lui upper 20 bits
  typedef struct packed {
    op_kind_t          kind;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic [19:0]       imm;
    logic              valid;
    logic              ill;
  } row_t;

  logic           clk;
  logic           rst;
  rv_pkg::instr_t instr;
  logic           instr_valid;
  logic           illegal_instr;
  logic           writebacked;
  rv_pkg::xlen_t  regs_o [`REG_COUNT];

  row_t           rows [$];
  // shadow copy of the architectural registers
  rv_pkg::xlen_t  shadow [`REG_COUNT];
  logic           prev_wen;
  int             word_errors;
  int             flag_errors;
  int             cycle_count;
  int             cycle_limit;

  exe_core u_exe_core (
    .clk           (clk),
    .rst           (rst),
    .instr         (instr),
    .instr_valid   (instr_valid),
    .illegal_instr (illegal_instr),
    .writebacked   (writebacked),
    .regs_o        (regs_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit, twice the table plus reset
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the table never finished", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input rv_pkg::xlen_t got, input rv_pkg::xlen_t exp,
                            input string msg);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      word_errors++;
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string msg);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got %0b expected %0b", $time, msg, got, exp);
      flag_errors++;
    end
  endtask

  task automatic check_regs(input rv_pkg::xlen_t got [`REG_COUNT],
                            input rv_pkg::xlen_t exp [`REG_COUNT], input string where);
    for (int i = 0; i < `REG_COUNT; i++) begin
      check_word(got[i], exp[i], $sformatf("%s regs_o x%0d", where, i));
    end
  endtask

  task automatic add_row(input op_kind_t kind, input rv_pkg::reg_addr_t rd,
                         input rv_pkg::reg_addr_t rs1, input rv_pkg::reg_addr_t rs2,
                         input logic [19:0] imm, input logic valid, input logic ill);
    rows.push_back('{kind, rd, rs1, rs2, imm, valid, ill});
  endtask

  function automatic rv_pkg::xlen_t sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // expected results under the rv64i rules
  function automatic rv_pkg::xlen_t model_result(input op_kind_t kind, input rv_pkg::xlen_t a,
                                                 input rv_pkg::xlen_t b, input logic [19:0] imm);
    rv_pkg::xlen_t i_imm;
    i_imm = {{52{imm[11]}}, imm[11:0]};
    case (kind)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_SLL:   return a << b[5:0];
      K_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      K_SLTU:  return (a < b) ? 64'd1 : 64'd0;
      K_XOR:   return a ^ b;
      K_SRL:   return a >> b[5:0];
      K_SRA:   return $signed(a) >>> b[5:0];
      K_OR:    return a | b;
      K_AND:   return a & b;
      K_ADDI:  return a + i_imm;
      K_SLTI:  return ($signed(a) < $signed(i_imm)) ? 64'd1 : 64'd0;
      K_SLTIU: return (a < i_imm) ? 64'd1 : 64'd0;
      K_XORI:  return a ^ i_imm;
      K_ORI:   return a | i_imm;
      K_ANDI:  return a & i_imm;
      K_SLLI:  return a << imm[5:0];
      K_SRLI:  return a >> imm[5:0];
      K_SRAI:  return $signed(a) >>> imm[5:0];
      K_LUI:   return {{32{imm[19]}}, imm, 12'h000};
      K_ADDW:  return sext32(a[31:0] + b[31:0]);
      K_SUBW:  return sext32(a[31:0] - b[31:0]);
      K_ADDIW: return sext32(a[31:0] + i_imm[31:0]);
      default: return a;
    endcase
  endfunction

  function automatic rv_pkg::instr_t encode(input row_t r);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    f7 = `RV_F7_BASE;
    case (r.kind)
      K_ADD:   {opc, f3} = {`RV_OP_REG, `RV_F3_ADD_SUB};
      K_SUB:   {opc, f3, f7} = {`RV_OP_REG, `RV_F3_ADD_SUB, `RV_F7_ALT};
      K_SLL:   {opc, f3} = {`RV_OP_REG, `RV_F3_SLL};
      K_SLT:   {opc, f3} = {`RV_OP_REG, `RV_F3_SLT};
      K_SLTU:  {opc, f3} = {`RV_OP_REG, `RV_F3_SLTU};
      K_XOR:   {opc, f3} = {`RV_OP_REG, `RV_F3_XOR};
      K_SRL:   {opc, f3} = {`RV_OP_REG, `RV_F3_SRL_SRA};
      K_SRA:   {opc, f3, f7} = {`RV_OP_REG, `RV_F3_SRL_SRA, `RV_F7_ALT};
      K_OR:    {opc, f3} = {`RV_OP_REG, `RV_F3_OR};
      K_AND:   {opc, f3} = {`RV_OP_REG, `RV_F3_AND};
      K_ADDI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_ADD_SUB};
      K_SLTI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_SLT};
      K_SLTIU: {opc, f3} = {`RV_OP_IMM, `RV_F3_SLTU};
      K_XORI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_XOR};
      K_ORI:   {opc, f3} = {`RV_OP_IMM, `RV_F3_OR};
      K_ANDI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_AND};
      K_SLLI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_SLL};
      K_SRLI:  {opc, f3} = {`RV_OP_IMM, `RV_F3_SRL_SRA};
      K_SRAI:  {opc, f3, f7} = {`RV_OP_IMM, `RV_F3_SRL_SRA, `RV_F7_ALT};
      K_LUI:   {opc, f3} = {`RV_OP_LUI, 3'b000};
      K_ADDW:  {opc, f3} = {`RV_OP_REG32, `RV_F3_ADD_SUB};
      K_SUBW:  {opc, f3, f7} = {`RV_OP_REG32, `RV_F3_ADD_SUB, `RV_F7_ALT};
      K_ADDIW: {opc, f3} = {`RV_OP_IMM32, `RV_F3_ADD_SUB};
      // mul encoding, outside the supported set
      default: {opc, f3, f7} = {`RV_OP_REG, `RV_F3_ADD_SUB, 7'b0000001};
    endcase
    // shift immediates carry funct6 above a 6-bit shamt
    if ((opc == `RV_OP_IMM) && ((f3 == `RV_F3_SLL) || (f3 == `RV_F3_SRL_SRA))) begin
      imm12 = {f7[6:1], r.imm[5:0]};
    end else begin
      imm12 = r.imm[11:0];
    end
    case (opc)
      `RV_OP_LUI:               return {r.imm, r.rd, opc};
      `RV_OP_IMM, `RV_OP_IMM32: return {imm12, r.rs1, f3, r.rd, opc};
      default:                  return {f7, r.rs2, r.rs1, f3, r.rd, opc};
    endcase
  endfunction

  task automatic apply_row(input row_t r, input int idx);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    logic          wen;
    @(posedge clk);
    #2;
    instr       = encode(r);
    instr_valid = r.valid;
    wen         = r.valid && !r.ill;
    a           = shadow[r.rs1];
    b           = shadow[r.rs2];
    // x0 writes still raise rd_wen but never land
    if (wen && (r.rd != 5'd0)) begin
      shadow[r.rd] = model_result(r.kind, a, b, r.imm);
    end
    // pending write already shows on regs_o
    @(negedge clk);
    check_flag(illegal_instr, r.valid && r.ill, $sformatf("row %0d illegal_instr", idx));
    check_flag(writebacked, prev_wen, $sformatf("row %0d writebacked", idx));
    check_regs(regs_o, shadow, $sformatf("row %0d", idx));
    prev_wen = wen;
  endtask

  initial begin
    rst         = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    prev_wen    = 1'b1;
    word_errors = 0;
    flag_errors = 0;
    cycle_count = 0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      shadow[i] = '0;
    end
    // immediates and lui, negative values included
    add_row(K_ADDI,  5'd1,  5'd0,  5'd0,  20'h00005, 1'b1, 1'b0);
    add_row(K_ADDI,  5'd2,  5'd0,  5'd0,  20'h00ffd, 1'b1, 1'b0);
    add_row(K_LUI,   5'd3,  5'd0,  5'd0,  20'h80000, 1'b1, 1'b0);
    add_row(K_ADDI,  5'd3,  5'd3,  5'd0,  20'h007ff, 1'b1, 1'b0);
    add_row(K_LUI,   5'd4,  5'd0,  5'd0,  20'h12345, 1'b1, 1'b0);
    add_row(K_XORI,  5'd5,  5'd2,  5'd0,  20'h000f0, 1'b1, 1'b0);
    add_row(K_ORI,   5'd6,  5'd1,  5'd0,  20'h00f00, 1'b1, 1'b0);
    add_row(K_ANDI,  5'd7,  5'd4,  5'd0,  20'h007f0, 1'b1, 1'b0);
    add_row(K_SLTI,  5'd8,  5'd2,  5'd0,  20'h00000, 1'b1, 1'b0);
    add_row(K_SLTIU, 5'd9,  5'd2,  5'd0,  20'h00005, 1'b1, 1'b0);
    add_row(K_SLLI,  5'd10, 5'd1,  5'd0,  20'h00028, 1'b1, 1'b0);
    add_row(K_SRLI,  5'd11, 5'd2,  5'd0,  20'h00004, 1'b1, 1'b0);
    add_row(K_SRAI,  5'd12, 5'd2,  5'd0,  20'h00004, 1'b1, 1'b0);
    // register forms, signed against unsigned compares
    add_row(K_ADD,   5'd13, 5'd1,  5'd2,  20'h00000, 1'b1, 1'b0);
    add_row(K_SUB,   5'd14, 5'd2,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_SLL,   5'd15, 5'd4,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_SLT,   5'd16, 5'd2,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_SLTU,  5'd17, 5'd2,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_XOR,   5'd18, 5'd3,  5'd4,  20'h00000, 1'b1, 1'b0);
    add_row(K_SRL,   5'd19, 5'd3,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_SRA,   5'd20, 5'd3,  5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_OR,    5'd21, 5'd13, 5'd14, 20'h00000, 1'b1, 1'b0);
    add_row(K_AND,   5'd22, 5'd3,  5'd2,  20'h00000, 1'b1, 1'b0);
    add_row(K_ADD,   5'd22, 5'd22, 5'd22, 20'h00000, 1'b1, 1'b0);
    // word forms wrapping across the 32-bit sign
    add_row(K_ADDIW, 5'd24, 5'd3,  5'd0,  20'h00800, 1'b1, 1'b0);
    add_row(K_ADDIW, 5'd25, 5'd24, 5'd0,  20'h00001, 1'b1, 1'b0);
    add_row(K_ADDW,  5'd26, 5'd24, 5'd1,  20'h00000, 1'b1, 1'b0);
    add_row(K_SUBW,  5'd27, 5'd3,  5'd24, 20'h00000, 1'b1, 1'b0);
    // x0 target, idle cycle, illegal encoding
    add_row(K_ADDI,  5'd0,  5'd1,  5'd0,  20'h00007, 1'b1, 1'b0);
    add_row(K_ADDI,  5'd5,  5'd0,  5'd0,  20'h00001, 1'b0, 1'b0);
    add_row(K_ILL,   5'd6,  5'd1,  5'd2,  20'h00000, 1'b1, 1'b1);
    add_row(K_ADD,   5'd28, 5'd6,  5'd6,  20'h00000, 1'b1, 1'b0);
    add_row(K_ADD,   5'd29, 5'd1,  5'd1,  20'h00000, 1'b0, 1'b0);
    cycle_limit = (rows.size() + RESET_CYCLES) * 2;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_flag(writebacked, 1'b1, "writebacked after reset");
    check_flag(illegal_instr, 1'b0, "illegal_instr after reset");
    check_regs(regs_o, shadow, "after reset");
    // release cycle carries no instruction
    prev_wen = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i], i);
    end
    $display("errors: %0d word mismatches, %0d flag mismatches", word_errors, flag_errors);
    if ((word_errors + flag_errors) == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
